// ==== source/bus_pkg.sv ====
// Shared widths, address map, timer and interrupt constants and bus enums for the I/O bus
`default_nettype none

package bus_pkg;

    localparam int ADDR_WIDTH  = 27;
    localparam int DATA_WIDTH  = 64;
    localparam int UART_WIDTH  = 8;
    localparam int TIMER_WIDTH = 32;
    localparam int TICK_DIVIDE = 200;  // Clock cycles per timer tick
    localparam int IRQ_COUNT   = 3;
    localparam int IRQ_SEL_WIDTH = $clog2(IRQ_COUNT);

    typedef logic [DATA_WIDTH-1:0]    word_t;
    typedef logic [UART_WIDTH-1:0]    byte_t;
    typedef logic [IRQ_SEL_WIDTH-1:0] irq_sel_t;

    // Source numbers, lowest wins
    localparam irq_sel_t IRQ_SW    = 0;
    localparam irq_sel_t IRQ_TIMER = 1;
    localparam irq_sel_t IRQ_UART  = 2;

    localparam logic [ADDR_WIDTH-1:0] ADDR_UART     = 'h5000000;
    localparam logic [ADDR_WIDTH-1:0] ADDR_LEDS     = 'h5000C00;
    localparam logic [ADDR_WIDTH-1:0] ADDR_IRQ_EN   = 'h7fffff7;
    localparam logic [ADDR_WIDTH-1:0] ADDR_IRQ_TYPE = 'h7fffff6;
    localparam logic [ADDR_WIDTH-1:0] ADDR_SW_IRQ   = 'h7fffff5;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TMR_COMP = 'h7fffff4;

    localparam word_t UART_EMPTY_WORD = 'h100;
    localparam word_t UNMAPPED_WORD   = '1;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE,
        OP_INT_ACK
    } bus_op_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_RD, ST_WR, ST_INT,
        ST_UART_RD1, ST_UART_RD2, ST_UART_RD3,
        ST_WAIT
    } bus_state_t;

endpackage

`default_nettype wire

// ==== source/bus_request_latch.sv ====
// One-entry holding register between the core and the bus FSM, with registered completion
`default_nettype none

module bus_request_latch (
    input  logic                            CLK,
    input  logic                            RST,
    input  bus_pkg::bus_op_t                core_op,
    input  logic [bus_pkg::ADDR_WIDTH-1:0]  core_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0]  core_wdata,
    input  logic                            bus_done,
    input  logic [bus_pkg::DATA_WIDTH-1:0]  bus_rdata,
    output bus_pkg::bus_op_t                req_op,
    output logic [bus_pkg::ADDR_WIDTH-1:0]  req_addr,
    output logic [bus_pkg::DATA_WIDTH-1:0]  req_wdata,
    output logic                            core_done,
    output logic [bus_pkg::DATA_WIDTH-1:0]  core_rdata
);

    logic capture;

    // Empty latch shows OP_NONE
    assign capture = (req_op == bus_pkg::OP_NONE) && (core_op != bus_pkg::OP_NONE);

    always_ff @(posedge CLK) begin
        if (RST) begin
            req_op    <= bus_pkg::OP_NONE;
            core_done <= 1'b0;
        end else begin
            core_done <= bus_done;
            if (bus_done) begin
                req_op <= bus_pkg::OP_NONE;  // Free for the next request
            end else if (capture) begin
                req_op <= core_op;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            req_addr  <= core_addr;
            req_wdata <= core_wdata;
        end
        if (bus_done) begin
            core_rdata <= bus_rdata;
        end
    end

    // Done from the FSM is a single pulse, so the core sees one too
    core_done_pulse: assert property (
        @(posedge CLK) disable iff (RST) core_done |=> !core_done
    ) else $error("core_done high for two cycles");

endmodule

`default_nettype wire

// ==== source/bus_fsm.sv ====
// Bus FSM decoding held requests to the UART FIFOs, LED, timer and interrupt registers
`default_nettype none

module bus_fsm (
    input  logic                             CLK,
    input  logic                             RST,
    input  bus_pkg::bus_op_t                 req_op,
    input  logic [bus_pkg::ADDR_WIDTH-1:0]   req_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0]   req_wdata,
    input  logic                             uart_rd_empty,
    input  logic [bus_pkg::UART_WIDTH-1:0]   uart_rd_data,
    input  logic                             uart_wr_full,
    input  logic [bus_pkg::TIMER_WIDTH-1:0]  timer_comp,
    input  logic [bus_pkg::IRQ_COUNT-1:0]    irq_en,
    input  logic [bus_pkg::IRQ_COUNT-1:0]    irq_type,
    input  logic [bus_pkg::UART_WIDTH-1:0]   irq_vector,
    output logic                             bus_done,
    output logic [bus_pkg::DATA_WIDTH-1:0]   bus_rdata,
    output logic                             uart_rd_re,
    output logic                             uart_wr_en,
    output logic [bus_pkg::UART_WIDTH-1:0]   uart_wr_data,
    output logic [bus_pkg::UART_WIDTH-1:0]   leds,
    output logic                             comp_we,
    output logic                             timer_clear,
    output logic                             en_we,
    output logic                             type_we,
    output logic                             sw_we,
    output logic                             irq_ack,
    output logic [bus_pkg::DATA_WIDTH-1:0]   wdata
);

    bus_pkg::bus_state_t state;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state       <= bus_pkg::ST_IDLE;
            bus_done    <= 1'b0;
            uart_rd_re  <= 1'b0;
            uart_wr_en  <= 1'b0;
            leds        <= '0;
            comp_we     <= 1'b0;
            timer_clear <= 1'b0;
            en_we       <= 1'b0;
            type_we     <= 1'b0;
            sw_we       <= 1'b0;
            irq_ack     <= 1'b0;
        end else begin
            case (state)
                bus_pkg::ST_IDLE: begin
                    wdata <= req_wdata;
                    case (req_op)
                        bus_pkg::OP_READ:    state <= bus_pkg::ST_RD;
                        bus_pkg::OP_WRITE:   state <= bus_pkg::ST_WR;
                        bus_pkg::OP_INT_ACK: state <= bus_pkg::ST_INT;
                        default: state <= bus_pkg::ST_IDLE;
                    endcase
                end
                bus_pkg::ST_RD: begin
                    state    <= bus_pkg::ST_WAIT;
                    bus_done <= 1'b1;
                    case (req_addr)
                        bus_pkg::ADDR_UART: begin
                            if (uart_rd_empty) begin
                                bus_rdata <= bus_pkg::UART_EMPTY_WORD;
                            end else begin
                                uart_rd_re <= 1'b1;  // Data comes three cycles later
                                bus_done   <= 1'b0;
                                state      <= bus_pkg::ST_UART_RD1;
                            end
                        end
                        bus_pkg::ADDR_LEDS:     bus_rdata <= bus_pkg::word_t'(leds);
                        bus_pkg::ADDR_IRQ_EN:   bus_rdata <= bus_pkg::word_t'(irq_en);
                        bus_pkg::ADDR_IRQ_TYPE: bus_rdata <= bus_pkg::word_t'(irq_type);
                        bus_pkg::ADDR_TMR_COMP: begin
                            bus_rdata   <= bus_pkg::word_t'(timer_comp);
                            timer_clear <= 1'b1;  // Reading the comparator rearms the timer
                        end
                        default: bus_rdata <= bus_pkg::UNMAPPED_WORD;
                    endcase
                end
                bus_pkg::ST_UART_RD1: begin
                    uart_rd_re <= 1'b0;
                    state      <= bus_pkg::ST_UART_RD2;
                end
                bus_pkg::ST_UART_RD2: begin
                    state <= bus_pkg::ST_UART_RD3;
                end
                bus_pkg::ST_UART_RD3: begin
                    bus_rdata <= bus_pkg::word_t'(uart_rd_data);
                    bus_done  <= 1'b1;
                    state     <= bus_pkg::ST_WAIT;
                end
                bus_pkg::ST_WR: begin
                    state    <= bus_pkg::ST_WAIT;
                    bus_done <= 1'b1;
                    case (req_addr)
                        bus_pkg::ADDR_UART: begin
                            if (uart_wr_full) begin
                                bus_done <= 1'b0;  // Hold until the FIFO has room
                                state    <= bus_pkg::ST_WR;
                            end else begin
                                uart_wr_en   <= 1'b1;
                                uart_wr_data <= wdata[bus_pkg::UART_WIDTH-1:0];
                            end
                        end
                        bus_pkg::ADDR_LEDS:     leds <= wdata[bus_pkg::UART_WIDTH-1:0];
                        bus_pkg::ADDR_IRQ_EN:   en_we <= 1'b1;
                        bus_pkg::ADDR_IRQ_TYPE: type_we <= 1'b1;
                        bus_pkg::ADDR_SW_IRQ:   sw_we <= 1'b1;
                        bus_pkg::ADDR_TMR_COMP: comp_we <= 1'b1;
                        default: begin
                        end
                    endcase
                end
                bus_pkg::ST_INT: begin
                    bus_rdata <= bus_pkg::word_t'(irq_vector);
                    irq_ack   <= 1'b1;
                    bus_done  <= 1'b1;
                    state     <= bus_pkg::ST_WAIT;
                end
                bus_pkg::ST_WAIT: begin
                    bus_done    <= 1'b0;
                    uart_wr_en  <= 1'b0;
                    comp_we     <= 1'b0;
                    timer_clear <= 1'b0;
                    en_we       <= 1'b0;
                    type_we     <= 1'b0;
                    sw_we       <= 1'b0;
                    irq_ack     <= 1'b0;
                    state       <= bus_pkg::ST_IDLE;
                end
                default: state <= bus_pkg::ST_IDLE;
            endcase
        end
    end

    // Transmit FIFO flag is outside, the strobe must still respect it
    uart_wr_no_overflow: assert property (
        @(posedge CLK) disable iff (RST) uart_wr_en |-> !uart_wr_full
    ) else $error("uart_wr_en while uart_wr_full");

endmodule

`default_nettype wire

// ==== source/tick_timer.sv ====
// Prescaled tick timer with compare register, raising the timer interrupt level on a match
`default_nettype none

module tick_timer (
    input  logic                             CLK,
    input  logic                             RST,
    input  logic                             comp_we,
    input  logic [bus_pkg::DATA_WIDTH-1:0]   wdata,
    input  logic                             timer_clear,
    output logic [bus_pkg::TIMER_WIDTH-1:0]  timer_comp,
    output logic                             timer_irq
);

    logic [$clog2(bus_pkg::TICK_DIVIDE)-1:0] prescale;
    logic [bus_pkg::TIMER_WIDTH-1:0]         tick;

    always_ff @(posedge CLK) begin
        if (RST) begin
            timer_comp <= '0;
        end else if (comp_we) begin
            timer_comp <= wdata[bus_pkg::TIMER_WIDTH-1:0];
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            prescale  <= '0;
            tick      <= '0;
            timer_irq <= 1'b0;
        end else if (timer_clear) begin
            prescale  <= '0;
            tick      <= '0;
            timer_irq <= 1'b0;
        end else if (!timer_irq && (timer_comp != '0)) begin  // Stopped while pending or unset
            if (int'(prescale) == bus_pkg::TICK_DIVIDE - 1) begin
                prescale <= '0;
                tick     <= tick + 1'b1;
            end else begin
                prescale <= prescale + 1'b1;
            end
            if (tick == timer_comp) begin
                tick      <= '0;  // Wins over the increment above
                timer_irq <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/irq_controller.sv ====
// Three-source interrupt controller with enable, level/edge type, fixed priority and acknowledge
`default_nettype none

module irq_controller (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            en_we,
    input  logic                            type_we,
    input  logic                            sw_we,
    input  logic [bus_pkg::DATA_WIDTH-1:0]  wdata,
    input  logic                            irq_ack,
    input  logic                            timer_irq,
    input  logic                            uart_rd_empty,
    output logic [bus_pkg::IRQ_COUNT-1:0]   irq_en,
    output logic [bus_pkg::IRQ_COUNT-1:0]   irq_type,
    output logic [bus_pkg::UART_WIDTH-1:0]  irq_vector,
    output logic                            core_intr
);

    logic [bus_pkg::IRQ_COUNT-1:0] irq_in;
    logic [bus_pkg::IRQ_COUNT-1:0] irq_old;
    logic [bus_pkg::IRQ_COUNT-1:0] pending;
    logic                          sw_level;
    bus_pkg::byte_t                sw_vector;
    bus_pkg::irq_sel_t             sel;
    bus_pkg::irq_sel_t             taken;

    // Type 1 needs a rising edge
    assign pending = irq_in & irq_en & (~irq_type | ~irq_old);

    always_comb begin
        sel = bus_pkg::IRQ_SW;
        for (int i = bus_pkg::IRQ_COUNT - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel = bus_pkg::irq_sel_t'(i);  // Lowest number ends up selected
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            irq_in    <= '0;
            irq_old   <= '0;
            irq_en    <= '0;
            irq_type  <= '0;
            sw_level  <= 1'b0;
            core_intr <= 1'b0;
        end else begin
            irq_in[bus_pkg::IRQ_SW]    <= sw_level;
            irq_in[bus_pkg::IRQ_TIMER] <= timer_irq;
            irq_in[bus_pkg::IRQ_UART]  <= !uart_rd_empty;
            irq_old                    <= irq_in;
            if (sw_we) begin
                sw_level  <= wdata[16];
                sw_vector <= wdata[bus_pkg::UART_WIDTH-1:0];
            end
            if (type_we) begin
                irq_type <= wdata[bus_pkg::IRQ_COUNT-1:0];
            end
            if (en_we) begin
                irq_en <= wdata[bus_pkg::IRQ_COUNT-1:0];
            end
            if (core_intr) begin
                if (irq_ack) begin
                    core_intr     <= 1'b0;
                    irq_en[taken] <= 1'b0;  // Source must be re-enabled by software
                end
            end else if (pending != '0) begin
                core_intr  <= 1'b1;
                taken      <= sel;
                irq_vector <= (sel == bus_pkg::IRQ_SW) ? sw_vector : bus_pkg::byte_t'(sel);
            end
        end
    end

    // The core acknowledges only a raised line
    ack_while_intr: assert property (
        @(posedge CLK) disable iff (RST) irq_ack |-> core_intr
    ) else $error("irq_ack while core_intr low");

endmodule

`default_nettype wire

// ==== source/io_bus.sv ====
// Top of the I/O bus controller, connecting request latch, bus FSM, timer and interrupts
`default_nettype none

module io_bus (
    input  logic                            CLK,
    input  logic                            RST,
    input  bus_pkg::bus_op_t                core_op,
    input  logic [bus_pkg::ADDR_WIDTH-1:0]  core_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0]  core_wdata,
    input  logic                            uart_rd_empty,
    input  logic [bus_pkg::UART_WIDTH-1:0]  uart_rd_data,
    input  logic                            uart_wr_full,
    output logic                            core_done,
    output logic [bus_pkg::DATA_WIDTH-1:0]  core_rdata,
    output logic                            core_intr,
    output logic                            uart_rd_re,
    output logic                            uart_wr_en,
    output logic [bus_pkg::UART_WIDTH-1:0]  uart_wr_data,
    output logic [bus_pkg::UART_WIDTH-1:0]  leds
);

    bus_pkg::bus_op_t                req_op;
    logic [bus_pkg::ADDR_WIDTH-1:0]  req_addr;
    logic [bus_pkg::DATA_WIDTH-1:0]  req_wdata, bus_rdata, wdata;
    logic                            bus_done, comp_we, timer_clear, timer_irq;
    logic                            en_we, type_we, sw_we, irq_ack;
    logic [bus_pkg::TIMER_WIDTH-1:0] timer_comp;
    logic [bus_pkg::IRQ_COUNT-1:0]   irq_en, irq_type;
    logic [bus_pkg::UART_WIDTH-1:0]  irq_vector;

    bus_request_latch i_bus_request_latch (.*);

    bus_fsm i_bus_fsm (.*);

    tick_timer i_tick_timer (.*);

    irq_controller i_irq_controller (.*);

endmodule

`default_nettype wire

// ==== test/tb_io_bus.sv ====
// Testbench for the I/O bus controller, compiled through verilog.f with tb_io_bus as top
`default_nettype none

module tb_io_bus;

    localparam int CLK_PERIOD  = 4;
    localparam int TEST_BUDGET = 2000;  // Cycles for the longest test
    localparam int TEST_COUNT  = 6;
    localparam int OP_TIMEOUT  = 100;
    localparam int TMR_COMPARE = 2;
    localparam logic [63:0] EN_SW    = 64'd1 << bus_pkg::IRQ_SW;
    localparam logic [63:0] EN_TIMER = 64'd1 << bus_pkg::IRQ_TIMER;
    localparam logic [63:0] EN_UART  = 64'd1 << bus_pkg::IRQ_UART;
    localparam logic [63:0] SW_LEVEL = 64'h1_0000;  // Bit 16 raises the software source

    logic                            CLK;
    logic                            RST;
    bus_pkg::bus_op_t                core_op;
    logic [bus_pkg::ADDR_WIDTH-1:0]  core_addr;
    logic [bus_pkg::DATA_WIDTH-1:0]  core_wdata;
    logic                            uart_rd_empty;
    logic [bus_pkg::UART_WIDTH-1:0]  uart_rd_data;
    logic                            uart_wr_full;
    logic                            core_done;
    logic [bus_pkg::DATA_WIDTH-1:0]  core_rdata;
    logic                            core_intr;
    logic                            uart_rd_re;
    logic                            uart_wr_en;
    logic [bus_pkg::UART_WIDTH-1:0]  uart_wr_data;
    logic [bus_pkg::UART_WIDTH-1:0]  leds;

    int             errors;
    int             seed;
    int             rd_pulses;
    int             wr_pulses;
    bit             pop_pending;
    bit             rdata_chk;
    bit             leds_chk;
    bit             intr_chk;
    bit             wr_hold;
    logic [63:0]    exp_rdata;
    logic [7:0]     exp_leds;
    logic [7:0]     exp_wr_data;
    logic           exp_intr;
    bus_pkg::byte_t rx_fifo[$];
    bus_pkg::byte_t rx_expected[$];

    io_bus i_io_bus (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Receive FIFO, a read strobe moves the next byte out one cycle later
    always @(posedge CLK) begin
        #1;
        if (pop_pending && rx_fifo.size() > 0) begin
            uart_rd_data = rx_fifo.pop_front();
        end
        pop_pending   = uart_rd_re;
        uart_rd_empty = (rx_fifo.size() == 0);
    end

    always @(negedge CLK) begin
        if (uart_rd_re) begin
            rd_pulses++;
        end
        if (uart_wr_en) begin
            wr_pulses++;
        end
    end

    rdata_value: assert property (@(negedge CLK) disable iff (RST)
        rdata_chk && core_done |-> core_rdata == exp_rdata)
        else report_mismatch("core_rdata", exp_rdata, core_rdata);
    leds_value: assert property (@(negedge CLK) disable iff (RST)
        leds_chk |-> leds == exp_leds)
        else report_mismatch("leds", 64'(exp_leds), 64'(leds));
    intr_level: assert property (@(negedge CLK) disable iff (RST)
        intr_chk |-> core_intr == exp_intr)
        else report_mismatch("core_intr", 64'(exp_intr), 64'(core_intr));
    wr_data_value: assert property (@(negedge CLK) disable iff (RST)
        uart_wr_en |-> uart_wr_data == exp_wr_data)
        else report_mismatch("uart_wr_data", 64'(exp_wr_data), 64'(uart_wr_data));
    full_blocks_write: assert property (@(negedge CLK) disable iff (RST)
        wr_hold |-> !core_done && !uart_wr_en)
        else report_mismatch("core_done, uart_wr_en", 64'd0, 64'({core_done, uart_wr_en}));
    rd_re_single: assert property (@(negedge CLK) disable iff (RST)
        uart_rd_re |=> !uart_rd_re)
        else report_mismatch("uart_rd_re", 64'd0, 64'(uart_rd_re));

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic next_random(output logic [63:0] value);
        logic [31:0] hi;
        logic [31:0] lo;
        hi    = $random(seed);
        lo    = $random(seed);
        value = {hi, lo};
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        do begin
            @(posedge CLK);
            #1;
            cycles++;
        end while (!core_done && cycles < OP_TIMEOUT);
        if (!core_done) begin
            errors++;
            $display("No core_done within %0d cycles for address %h", OP_TIMEOUT, core_addr);
        end
        core_op = bus_pkg::OP_NONE;  // Dropped while done is high
        @(posedge CLK);
        #1;
    endtask

    task automatic run_op(input bus_pkg::bus_op_t op, input logic [bus_pkg::ADDR_WIDTH-1:0] addr,
                          input logic [63:0] data, input bit check, input logic [63:0] expected);
        rdata_chk  = check;
        exp_rdata  = expected;
        core_op    = op;
        core_addr  = addr;
        core_wdata = data;
        wait_done();
    endtask

    task automatic write_reg(input logic [bus_pkg::ADDR_WIDTH-1:0] addr, input logic [63:0] data);
        run_op(bus_pkg::OP_WRITE, addr, data, 1'b0, 64'd0);
    endtask

    task automatic read_expect(input logic [bus_pkg::ADDR_WIDTH-1:0] addr,
                               input logic [63:0] expected);
        run_op(bus_pkg::OP_READ, addr, 64'd0, 1'b1, expected);
    endtask

    task automatic wait_intr(input int bound);
        int cycles;
        cycles = 0;
        while (!core_intr && cycles < bound) begin
            @(posedge CLK);
            #1;
            cycles++;
        end
        assert (core_intr) else begin
            errors++;
            $display("core_intr did not rise within %0d cycles", bound);
        end
    endtask

    task automatic watch_intr(input logic level, input int cycles);
        exp_intr = level;
        intr_chk = 1'b1;
        repeat (cycles) @(posedge CLK);
        #1;
        intr_chk = 1'b0;
    endtask

    initial begin
        logic [63:0] value;
        logic [7:0]  vector;
        CLK           = 1'b0;
        RST           = 1'b1;
        core_op       = bus_pkg::OP_NONE;
        core_addr     = '0;
        core_wdata    = '0;
        uart_rd_empty = 1'b1;
        uart_rd_data  = '0;
        uart_wr_full  = 1'b0;
        errors        = 0;
        seed          = 32'hc6b0;
        repeat (2) @(posedge CLK);
        #1;
        RST = 1'b0;
        @(negedge CLK);
        assert ({core_done, core_intr, uart_rd_re, uart_wr_en, leds} == 12'h000)
            else report_mismatch("reset outputs", 64'd0,
                                 64'({core_done, core_intr, uart_rd_re, uart_wr_en, leds}));
        @(posedge CLK);
        #1;

        next_random(value);
        write_reg(bus_pkg::ADDR_LEDS, value);
        exp_leds = value[7:0];
        leds_chk = 1'b1;
        read_expect(bus_pkg::ADDR_LEDS, 64'(value[7:0]));
        leds_chk = 1'b0;
        next_random(value);
        write_reg(bus_pkg::ADDR_IRQ_EN, value);
        read_expect(bus_pkg::ADDR_IRQ_EN, 64'(value[2:0]));
        next_random(value);
        write_reg(bus_pkg::ADDR_IRQ_TYPE, value);
        read_expect(bus_pkg::ADDR_IRQ_TYPE, 64'(value[2:0]));
        write_reg(bus_pkg::ADDR_IRQ_EN, 64'd0);
        write_reg(bus_pkg::ADDR_IRQ_TYPE, 64'd0);
        read_expect(27'h0001234, {64{1'b1}});

        // Transmit FIFO full holds the write in the FSM
        next_random(value);
        exp_wr_data  = value[7:0];
        wr_pulses    = 0;
        uart_wr_full = 1'b1;
        rdata_chk    = 1'b0;
        core_op      = bus_pkg::OP_WRITE;
        core_addr    = bus_pkg::ADDR_UART;
        core_wdata   = value;
        wr_hold      = 1'b1;
        repeat (8) @(posedge CLK);
        #1;
        wr_hold      = 1'b0;
        uart_wr_full = 1'b0;
        wait_done();
        assert (wr_pulses == 1) else report_mismatch("uart_wr_en pulses", 64'd1, 64'(wr_pulses));

        read_expect(bus_pkg::ADDR_UART, 64'h100);
        for (int i = 0; i < 3; i++) begin
            next_random(value);
            rx_fifo.push_back(value[7:0]);
            rx_expected.push_back(value[7:0]);
        end
        @(posedge CLK);
        #1;
        while (rx_expected.size() > 0) begin
            rd_pulses = 0;
            read_expect(bus_pkg::ADDR_UART, 64'(rx_expected.pop_front()));
            assert (rd_pulses == 1)
                else report_mismatch("uart_rd_re pulses", 64'd1, 64'(rd_pulses));
        end

        write_reg(bus_pkg::ADDR_TMR_COMP, 64'(TMR_COMPARE));
        write_reg(bus_pkg::ADDR_IRQ_EN, EN_TIMER);
        wait_intr((TMR_COMPARE + 2) * bus_pkg::TICK_DIVIDE);
        run_op(bus_pkg::OP_INT_ACK, '0, 64'd0, 1'b1, 64'd1);
        watch_intr(1'b0, 2);
        read_expect(bus_pkg::ADDR_IRQ_EN, 64'd0);
        read_expect(bus_pkg::ADDR_TMR_COMP, 64'(TMR_COMPARE));
        assert (!i_io_bus.i_tick_timer.timer_irq)
            else report_mismatch("timer_irq", 64'd0, 64'(i_io_bus.i_tick_timer.timer_irq));
        write_reg(bus_pkg::ADDR_TMR_COMP, 64'd0);  // Stop the timer

        // Software and UART pending together, software wins
        next_random(value);
        vector = value[7:0];
        rx_fifo.push_back(value[15:8]);
        rx_expected.push_back(value[15:8]);
        write_reg(bus_pkg::ADDR_SW_IRQ, SW_LEVEL | 64'(vector));
        write_reg(bus_pkg::ADDR_IRQ_EN, EN_SW | EN_UART);
        wait_intr(OP_TIMEOUT);
        run_op(bus_pkg::OP_INT_ACK, '0, 64'd0, 1'b1, 64'(vector));
        wait_intr(OP_TIMEOUT);
        run_op(bus_pkg::OP_INT_ACK, '0, 64'd0, 1'b1, 64'd2);
        read_expect(bus_pkg::ADDR_UART, 64'(rx_expected.pop_front()));

        write_reg(bus_pkg::ADDR_SW_IRQ, 64'd0);
        write_reg(bus_pkg::ADDR_IRQ_TYPE, EN_SW);
        write_reg(bus_pkg::ADDR_IRQ_EN, EN_SW);
        next_random(value);
        vector = value[7:0];
        write_reg(bus_pkg::ADDR_SW_IRQ, SW_LEVEL | 64'(vector));
        wait_intr(OP_TIMEOUT);
        run_op(bus_pkg::OP_INT_ACK, '0, 64'd0, 1'b1, 64'(vector));
        write_reg(bus_pkg::ADDR_IRQ_EN, EN_SW);
        watch_intr(1'b0, 20);  // Level still high, no new edge

        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (TEST_BUDGET * TEST_COUNT) @(posedge CLK);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 TEST_BUDGET * TEST_COUNT);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/bus_pkg.sv
source/bus_request_latch.sv
source/bus_fsm.sv
source/tick_timer.sv
source/irq_controller.sv
source/io_bus.sv
test/tb_io_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the I/O bus testbench with Verilator, run it and check the log for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_io_bus -f verilog.f -o tb_io_bus
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_io_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
